//--- logic/lcd_pkg.sv
package lcd_pkg;

	// timing base, all delays below are in units of one microsecond
	localparam int CLK_PER_UNIT = 3;              // clocks per unit

	localparam int POWERUP_UNITS = 500;           // panel power-up settle
	localparam int SETUP_UNITS   = 1;             // rs/rw/data to e rise
	localparam int E_HIGH_UNITS  = 13;            // enable pulse width

	// derived cycle counts
	localparam int POWERUP_CYCLES = POWERUP_UNITS * CLK_PER_UNIT;
	localparam int SETUP_CYCLES   = SETUP_UNITS * CLK_PER_UNIT;
	localparam int E_HIGH_CYCLES  = E_HIGH_UNITS * CLK_PER_UNIT;

	// hold field carried with each request
	localparam int HOLD_W = 8;

	// total transfer length per command, in units
	localparam logic [HOLD_W-1:0] HOLD_HOST_UNITS  = 8'd50;
	localparam logic [HOLD_W-1:0] HOLD_FSET_UNITS  = 8'd50;
	localparam logic [HOLD_W-1:0] HOLD_DISP_UNITS  = 8'd50;
	localparam logic [HOLD_W-1:0] HOLD_CLEAR_UNITS = 8'd200;   // clear is slow on the panel
	localparam logic [HOLD_W-1:0] HOLD_ENTRY_UNITS = 8'd100;

	// fixed upper bits of the init commands
	localparam logic [7:0] OP_FUNCTION_SET = 8'b0011_0000;   // 8-bit bus
	localparam logic [7:0] OP_DISPLAY_CTRL = 8'b0000_1000;
	localparam logic [7:0] OP_CLEAR        = 8'b0000_0001;
	localparam logic [7:0] OP_ENTRY_MODE   = 8'b0000_0100;

	// bit positions in the 7-bit cfg word
	localparam int CFG_LINES   = 6;               // N, two-line display
	localparam int CFG_FONT    = 5;               // F, 5x10 font
	localparam int CFG_DISP_ON = 4;               // D
	localparam int CFG_CURSOR  = 3;               // C
	localparam int CFG_BLINK   = 2;               // B
	localparam int CFG_INC     = 1;               // I/D, address increment
	localparam int CFG_SHIFT   = 0;               // S, display shift

endpackage

//--- logic/lcd_xfer_if.sv
`timescale 1ns/1ps

// one panel transfer request and its completion
interface lcd_xfer_if;

	logic                         start;        // one-cycle request pulse
	logic                         rs;
	logic                         rw;
	logic [7:0]                   data;
	logic [lcd_pkg::HOLD_W-1:0]   hold_units;   // total transfer length
	logic                         done;         // last cycle of transfer

	modport source (
		output start, rs, rw, data, hold_units,
		input  done
	);

	modport sink (
		input  start, rs, rw, data, hold_units,
		output done
	);

	modport monitor (
		input start, rs, rw, data, hold_units, done
	);

endinterface

//--- logic/lcd_init_seq.sv
`timescale 1ns/1ps

module lcd_init_seq (
	input  logic             clk,
	input  logic             rst_n,
	input  logic [6:0]       cfg,
	lcd_xfer_if.source       xfer,
	output logic             init_done
);

	typedef enum logic [1:0] {
		ST_PWR,      // power-up wait
		ST_CMD,      // issue start for current command
		ST_WAIT,     // wait for strobe done
		ST_DONE
	} state_t;

	state_t state;
	logic [1:0] cmd_idx;                                          // 0 fset .. 3 entry
	logic [$clog2(lcd_pkg::POWERUP_CYCLES)-1:0] pwr_cnt;
	logic [7:0] cmd;
	logic [lcd_pkg::HOLD_W-1:0] hold;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_PWR;
			cmd_idx <= 2'd0;
			pwr_cnt <= '0;
		end else begin
			case (state)
				ST_PWR: begin
					if (int'(pwr_cnt) == lcd_pkg::POWERUP_CYCLES - 1) begin
						state <= ST_CMD;
					end else begin
						pwr_cnt <= pwr_cnt + 1'b1;
					end
				end
				ST_CMD: begin
					state <= ST_WAIT;                              // start is high this cycle
				end
				ST_WAIT: begin
					if (xfer.done) begin
						if (cmd_idx == 2'd3) begin
							state <= ST_DONE;
						end else begin
							cmd_idx <= cmd_idx + 2'd1;
							state   <= ST_CMD;                     // next start right after done
						end
					end
				end
				default: begin
					state <= ST_DONE;                              // stays here until reset
				end
			endcase
		end
	end

	// command byte and hold time for the current step
	always_comb begin
		cmd  = lcd_pkg::OP_CLEAR;
		hold = lcd_pkg::HOLD_CLEAR_UNITS;
		case (cmd_idx)
			2'd0: begin
				cmd    = lcd_pkg::OP_FUNCTION_SET;
				cmd[3] = cfg[lcd_pkg::CFG_LINES];
				cmd[2] = cfg[lcd_pkg::CFG_FONT];
				hold   = lcd_pkg::HOLD_FSET_UNITS;
			end
			2'd1: begin
				cmd    = lcd_pkg::OP_DISPLAY_CTRL;
				cmd[2] = cfg[lcd_pkg::CFG_DISP_ON];
				cmd[1] = cfg[lcd_pkg::CFG_CURSOR];
				cmd[0] = cfg[lcd_pkg::CFG_BLINK];
				hold   = lcd_pkg::HOLD_DISP_UNITS;
			end
			2'd3: begin
				cmd    = lcd_pkg::OP_ENTRY_MODE;
				cmd[1] = cfg[lcd_pkg::CFG_INC];
				cmd[0] = cfg[lcd_pkg::CFG_SHIFT];
				hold   = lcd_pkg::HOLD_ENTRY_UNITS;
			end
			default: begin
				cmd  = lcd_pkg::OP_CLEAR;                          // display clear
				hold = lcd_pkg::HOLD_CLEAR_UNITS;
			end
		endcase
	end

	assign xfer.start      = (state == ST_CMD);
	assign xfer.rs         = 1'b0;                                // init writes are instructions
	assign xfer.rw         = 1'b0;
	assign xfer.data       = cmd;
	assign xfer.hold_units = hold;

	assign init_done = (state == ST_DONE);

	// once up, the panel stays initialized until the next reset
	init_done_sticky: assert property (
		@(posedge clk) disable iff (!rst_n)
		init_done |=> init_done
	);

endmodule

//--- logic/lcd_strobe_gen.sv
`timescale 1ns/1ps

module lcd_strobe_gen (
	input  logic        clk,
	input  logic        rst_n,
	lcd_xfer_if.sink    xfer,
	output logic        e,
	output logic [7:0]  lcd_data,
	output logic        rs,
	output logic        rw
);

	logic                         active;        // transfer in progress
	logic [lcd_pkg::HOLD_W-1:0]   hold_q;
	logic [lcd_pkg::HOLD_W+1:0]   cnt;           // cycles since first pin cycle
	logic [lcd_pkg::HOLD_W+1:0]   cnt_nxt;
	logic                         last;
	logic                         e_nxt;

	assign cnt_nxt = cnt + 1'b1;

	// last cycle of hold_units * CLK_PER_UNIT
	assign last = active &&
		(int'(cnt) == int'(hold_q) * lcd_pkg::CLK_PER_UNIT - 1);

	// e window is SETUP_CYCLES after the pins settle, E_HIGH_CYCLES wide
	assign e_nxt = (int'(cnt_nxt) >= lcd_pkg::SETUP_CYCLES) &&
		(int'(cnt_nxt) < lcd_pkg::SETUP_CYCLES + lcd_pkg::E_HIGH_CYCLES);

	assign xfer.done = last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			cnt      <= '0;
			e        <= 1'b0;
			lcd_data <= 8'h00;
			rs       <= 1'b0;
			rw       <= 1'b0;
		end else if (!active) begin
			cnt <= '0;
			if (xfer.start) begin
				active   <= 1'b1;
				lcd_data <= xfer.data;                  // pins valid from next cycle
				rs       <= xfer.rs;
				rw       <= xfer.rw;
			end
		end else if (last) begin
			active   <= 1'b0;
			e        <= 1'b0;
			lcd_data <= 8'h00;                          // bus back to idle
			rs       <= 1'b0;
			rw       <= 1'b0;
		end else begin
			cnt <= cnt_nxt;
			e   <= e_nxt;
		end
	end

	// hold length, only meaningful while active
	always_ff @(posedge clk) begin
		if (!active && xfer.start) begin
			hold_q <= xfer.hold_units;
		end
	end

	// panel latches on falling e, so the bus must not move under it
	pins_stable_while_e: assert property (
		@(posedge clk) disable iff (!rst_n)
		e |=> !e || $stable({lcd_data, rs, rw})
	);

endmodule

//--- logic/lcd_controller.sv
`timescale 1ns/1ps

module lcd_controller (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [6:0]  cfg,
	input  logic        lcd_enable,
	input  logic [9:0]  lcd_bus,      // {rs, rw, data}
	output logic        e,
	output logic [7:0]  lcd_data,
	output logic        rw,
	output logic        rs,
	output logic        busy
);

	logic init_done;
	logic busy_q;                     // host transfer in flight
	logic accept;
	logic req_open;                   // strobe holds an unfinished request

	lcd_xfer_if init_req ();          // init sequencer request
	lcd_xfer_if xfer ();              // request seen by the strobe generator

	lcd_init_seq u_init (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg       (cfg),
		.xfer      (init_req.source),
		.init_done (init_done)
	);

	lcd_strobe_gen u_strobe (
		.clk      (clk),
		.rst_n    (rst_n),
		.xfer     (xfer.sink),
		.e        (e),
		.lcd_data (lcd_data),
		.rs       (rs),
		.rw       (rw)
	);

	// host word taken in the same cycle enable is seen idle
	assign accept = init_done && !busy_q && lcd_enable;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
		end else if (accept) begin
			busy_q <= 1'b1;
		end else if (xfer.done) begin
			busy_q <= 1'b0;                           // low the cycle after done
		end
	end

	assign busy = busy_q || !init_done;

	// init owns the strobe until it finishes and the host owns it after that
	always_comb begin
		if (init_done) begin
			xfer.start      = accept;
			xfer.rs         = lcd_bus[9];
			xfer.rw         = lcd_bus[8];
			xfer.data       = lcd_bus[7:0];
			xfer.hold_units = lcd_pkg::HOLD_HOST_UNITS;
		end else begin
			xfer.start      = init_req.start;
			xfer.rs         = init_req.rs;
			xfer.rw         = init_req.rw;
			xfer.data       = init_req.data;
			xfer.hold_units = init_req.hold_units;
		end
	end

	assign init_req.done = xfer.done && !init_done;

	// open from the start of a request to its done pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			req_open <= 1'b0;
		end else if (xfer.start) begin
			req_open <= 1'b1;
		end else if (xfer.done) begin
			req_open <= 1'b0;
		end
	end

	// enable pulses only inside an init or host transfer
	e_only_in_transfer: assert property (
		@(posedge clk) disable iff (!rst_n)
		e |-> busy
	);

	// a busy strobe never gets a second request
	no_start_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(xfer.start && req_open)
	);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	input  logic reset_req,     // extra reset from the testbench
	output logic clk,
	output logic rst_n
);

	localparam real HALF_PERIOD = 4.0;   // 8 ns period

	logic por_n;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// power-on reset, low for three rising edges
	initial begin
		por_n = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		por_n = 1'b1;
	end

	assign rst_n = por_n && !reset_req;

endmodule

//--- test/lcd_tb.sv
`timescale 1ns/1ps

module lcd_tb;

	localparam int CLK_PERIOD  = 8;
	localparam int E_WIDTH     = lcd_pkg::E_HIGH_UNITS * lcd_pkg::CLK_PER_UNIT;
	localparam int HOST_CYCLES = int'(lcd_pkg::HOLD_HOST_UNITS) * lcd_pkg::CLK_PER_UNIT;
	localparam int INIT_XFER_CYCLES = (int'(lcd_pkg::HOLD_FSET_UNITS) +
		int'(lcd_pkg::HOLD_DISP_UNITS) + int'(lcd_pkg::HOLD_CLEAR_UNITS) +
		int'(lcd_pkg::HOLD_ENTRY_UNITS)) * lcd_pkg::CLK_PER_UNIT + 16;
	localparam int INIT_CYCLES = lcd_pkg::POWERUP_UNITS * lcd_pkg::CLK_PER_UNIT +
		INIT_XFER_CYCLES;
	// twice the length of three init runs and about forty host transfers
	localparam int WATCHDOG_CYCLES = 2 * (3 * INIT_CYCLES + 40 * HOST_CYCLES);
	localparam logic [31:0] LFSR_SEED = 32'd93183;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [6:0]  CFG_A = 7'b101_1010;
	localparam logic [6:0]  CFG_B = 7'b010_0101;
	localparam logic [6:0]  CFG_C = 7'b111_1111;

	logic        clk;
	logic        rst_n;
	logic        reset_req;
	logic [6:0]  cfg;
	logic        lcd_enable;
	logic [9:0]  lcd_bus;
	logic        e;
	logic [7:0]  lcd_data;
	logic        rw;
	logic        rs;
	logic        busy;

	logic [31:0] lfsr;
	int          width;                 // cycles of the current e pulse
	logic [9:0]  cap_word;
	logic [9:0]  rec_word[$];           // {rs, rw, data} per pulse
	int          rec_width[$];
	logic [9:0]  exp_word[$];

	tb_clock clkgen (
		.reset_req (reset_req),
		.clk       (clk),
		.rst_n     (rst_n)
	);

	lcd_controller uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.lcd_data   (lcd_data),
		.rw         (rw),
		.rs         (rs),
		.busy       (busy)
	);

	// one record per enable pulse on the pins
	always @(negedge clk) begin
		if (!rst_n) begin
			width = 0;                      // a pulse cut by reset is dropped
		end else if (e) begin
			width = width + 1;
			cap_word = {rs, rw, lcd_data};
		end else if (width != 0) begin
			rec_word.push_back(cap_word);
			rec_width.push_back(width);
			width = 0;
		end
	end

	task automatic abort_run();
		$display("RESULT: FAIL");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s %s: expected %0h actual %0h", name, what, expected, actual);
			abort_run();
		end
	endtask

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ LFSR_TAPS;
		end
		return state >> 1;
	endfunction

	task automatic next_word(output logic [9:0] w);
		int i;
		for (i = 0; i < 10; i++) begin
			w[i] = lfsr[0];
			lfsr = lfsr_next(lfsr);         // one step per bit
		end
	endtask

	// command byte as the panel expects it for init step idx
	function automatic logic [7:0] init_command(input int idx, input logic [6:0] c);
		logic [7:0] b;
		case (idx)
			0: b = lcd_pkg::OP_FUNCTION_SET |
				{4'b0, c[lcd_pkg::CFG_LINES], c[lcd_pkg::CFG_FONT], 2'b0};
			1: b = lcd_pkg::OP_DISPLAY_CTRL |
				{5'b0, c[lcd_pkg::CFG_DISP_ON], c[lcd_pkg::CFG_CURSOR], c[lcd_pkg::CFG_BLINK]};
			2: b = lcd_pkg::OP_CLEAR;
			default: b = lcd_pkg::OP_ENTRY_MODE |
				{6'b0, c[lcd_pkg::CFG_INC], c[lcd_pkg::CFG_SHIFT]};
		endcase
		return b;
	endfunction

	task automatic after_rise();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_records();
		rec_word.delete();
		rec_width.delete();
		exp_word.delete();
	endtask

	task automatic wait_idle(input string name, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (busy) begin
			n++;
			if (n > limit) begin
				$display("%s: busy still high after %0d cycles", name, limit);
				abort_run();
			end
			@(negedge clk);
		end
	endtask

	task automatic send_word(input logic [9:0] w);
		after_rise();
		lcd_enable = 1'b1;
		lcd_bus    = w;
		after_rise();
		lcd_enable = 1'b0;
	endtask

	task automatic compare_records(input string name);
		check(name, "pulse count", exp_word.size(), rec_word.size());
		foreach (exp_word[i]) begin
			check(name, "word", exp_word[i], rec_word[i]);
			check(name, "e width", E_WIDTH, rec_width[i]);
		end
	endtask

	task automatic restart(input logic [6:0] c);
		after_rise();
		cfg       = c;
		reset_req = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset_req = 1'b0;
		clear_records();
	endtask

	task automatic test_power_up(input string name);
		int i;
		for (i = 0; i < lcd_pkg::POWERUP_UNITS * lcd_pkg::CLK_PER_UNIT; i++) begin
			@(negedge clk);
			check(name, "busy", 1, busy);
			check(name, "e", 0, e);
		end
	endtask

	task automatic test_init(input string name, input logic [6:0] c);
		int i;
		wait_idle(name, INIT_XFER_CYCLES);
		for (i = 0; i < 4; i++) begin
			exp_word.push_back({2'b00, init_command(i, c)});   // rs and rw low
		end
		compare_records(name);             // all four done before busy fell
		clear_records();
	endtask

	task automatic test_single_write(input string name, input logic [9:0] w);
		int n;
		wait_idle(name, HOST_CYCLES);
		clear_records();
		after_rise();
		lcd_enable = 1'b1;
		lcd_bus    = w;
		@(negedge clk);
		check(name, "busy at accept", 0, busy);
		after_rise();
		lcd_enable = 1'b0;
		n = 1;
		@(negedge clk);
		check(name, "busy after accept", 1, busy);
		while (busy) begin
			@(negedge clk);
			n++;
			if (n > 2 * HOST_CYCLES) begin
				$display("%s: busy never fell after the write", name);
				abort_run();
			end
		end
		check(name, "busy fall cycle", HOST_CYCLES + 1, n);
		exp_word.push_back(w);
		compare_records(name);
		clear_records();
	endtask

	task automatic test_enable_while_busy();
		int i;
		logic [9:0] w;
		logic idle;
		wait_idle("enable_while_busy", HOST_CYCLES);
		clear_records();
		for (i = 0; i < 2 * HOST_CYCLES + 12; i++) begin
			next_word(w);
			idle = (i % (HOST_CYCLES + 1) == 0);   // busy drops the cycle after done
			after_rise();
			lcd_bus    = w;
			lcd_enable = 1'b1;
			@(negedge clk);
			check("enable_while_busy", "busy", !idle, busy);
			if (idle) begin
				exp_word.push_back(w);
			end
		end
		after_rise();
		lcd_enable = 1'b0;
		wait_idle("enable_while_busy", HOST_CYCLES);
		compare_records("enable_while_busy");
		clear_records();
	endtask

	task automatic test_random_writes();
		int i;
		logic [9:0] w;
		wait_idle("random_writes", HOST_CYCLES);
		clear_records();
		for (i = 0; i < 20; i++) begin
			next_word(w);
			exp_word.push_back(w);
			wait_idle("random_writes", HOST_CYCLES);
			send_word(w);
		end
		wait_idle("random_writes", HOST_CYCLES);
		compare_records("random_writes");
		clear_records();
	endtask

	task automatic test_reset_mid_transfer();
		int n;
		wait_idle("reset_mid", HOST_CYCLES);
		send_word(10'h2aa);
		n = 0;
		@(negedge clk);
		while (!e) begin
			n++;
			if (n > HOST_CYCLES) begin
				$display("reset_mid: enable pulse never started");
				abort_run();
			end
			@(negedge clk);
		end
		repeat (5) @(negedge clk);         // well inside the pulse
		after_rise();
		cfg       = CFG_C;
		reset_req = 1'b1;
		@(posedge clk);
		@(negedge clk);
		check("reset_mid", "e", 0, e);
		check("reset_mid", "rs", 0, rs);
		check("reset_mid", "rw", 0, rw);
		check("reset_mid", "lcd_data", 0, lcd_data);
		check("reset_mid", "busy", 1, busy);
		repeat (2) @(posedge clk);
		#1;
		reset_req = 1'b0;
		clear_records();
		test_power_up("reset_mid_power_up");
		test_init("reset_mid_init", CFG_C);
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: the run took longer than %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	initial begin
		reset_req   = 1'b0;
		cfg         = CFG_A;
		lcd_enable  = 1'b0;
		lcd_bus     = 10'h000;
		lfsr        = LFSR_SEED;
		width       = 0;
		cap_word    = 10'h000;
		wait (rst_n === 1'b1);
		clear_records();
		test_power_up("power_up");
		test_init("init_a", CFG_A);
		restart(CFG_B);
		test_power_up("power_up_b");
		test_init("init_b", CFG_B);
		test_single_write("single_write", 10'h241);
		test_enable_while_busy();
		test_random_writes();
		test_reset_mid_transfer();
		test_single_write("write_after_reset", 10'h1c3);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
logic/lcd_pkg.sv
logic/lcd_xfer_if.sv
logic/lcd_init_seq.sv
logic/lcd_strobe_gen.sv
logic/lcd_controller.sv
test/tb_clock.sv
test/lcd_tb.sv
